// File: soc_sysctl.f
+incdir+verilog
verilog/soc_sysctl_pkg.sv
verilog/soc_rst_seq.sv
verilog/pi1_decode.sv
verilog/soc_devtbl.sv
verilog/soc_gpio.sv
verilog/pi1_result.sv
verilog/soc_sysctl_top.sv
tests/soc_sysctl_chk.sv
tests/soc_sysctl_mon.sv
tests/soc_sysctl_tb.sv

// File: tests/soc_sysctl_chk.sv
`timescale 1ns/100ps
`default_nettype none

module soc_sysctl_chk (
	input wire logic clk_4x_w,
	input wire logic sys_rst_o,
	input wire logic pi1_rdy_o,
	input wire logic [7:0] gp_o,
	input wire logic [31:0] pi1_data_o
);

	// Bus stays closed while the system is held in reset
	a_rdy_in_reset: assert property (@(posedge clk_4x_w) sys_rst_o |-> !pi1_rdy_o)
		else $error("pi1_rdy_o high during system reset");

	// Output register clears one edge after reset rises
	a_gp_in_reset: assert property (@(posedge clk_4x_w)
		(sys_rst_o && $past(sys_rst_o)) |-> (gp_o[7:1] == 7'd0))
		else $error("gp_o[7:1] not zero during system reset");

	a_data_known: assert property (@(posedge clk_4x_w) !sys_rst_o |-> !$isunknown(pi1_data_o))
		else $error("pi1_data_o unknown while out of reset");

endmodule

bind soc_sysctl_top soc_sysctl_chk i_chk (
	.clk_4x_w(clk_4x_w),
	.sys_rst_o(sys_rst_o),
	.pi1_rdy_o(pi1_rdy_o),
	.gp_o(gp_o),
	.pi1_data_o(pi1_data_o)
);

`default_nettype wire

// File: tests/soc_sysctl_mon.sv
`timescale 1ns/100ps
`default_nettype none

module soc_sysctl_mon (
	input wire logic clk_4x_w,
	input wire logic sys_rst_o,
	input wire logic pi1_rdy_o,
	input wire logic [1:0] pi1_op_i,
	input wire logic [31:0] pi1_data_o,
	input wire logic [7:0] gp_o,
	input wire logic [31:0] exp_rd_i,
	input wire logic [7:0] exp_gp_i,
	input wire logic [8*16-1:0] test_name_i,
	input wire logic test_end_i,
	input wire logic all_done_i,
	input wire logic act_test_i,
	input wire logic cond_chk_i,
	input wire logic cond_ok_i,
	input wire logic [8*48-1:0] cond_msg_i,
	output int err_cnt_o
);

	logic s1_vld, s2_vld;
	logic [31:0] s1_rd, s2_rd;
	logic [7:0] s1_gp, s2_gp;
	logic [7:0] gp_model;
	logic act_seen;
	int idle_cnt;
	int test_errs;
	int tests_run;
	int tests_failed;

	initial begin
		s1_vld = 0;
		s2_vld = 0;
		gp_model = '0;
		act_seen = 0;
		idle_cnt = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		err_cnt_o = 0;
	end

	// Inputs and outputs are both settled at the falling edge
	always @(negedge clk_4x_w) begin
		// Oldest request has its read word on the bus now
		if (s2_vld) begin
			gp_model = s2_gp;
			if (pi1_data_o !== s2_rd) begin
				$display("** Error [%0s] read data expected %h, got %h",
					test_name_i, s2_rd, pi1_data_o);
				test_errs++;
			end
		end
		if (sys_rst_o === 1'b1)
			gp_model = '0;
		if (sys_rst_o === 1'b0) begin
			if (pi1_rdy_o !== 1'b1) begin
				$display("[%0s] pi1_rdy_o low while the system is out of reset",
					test_name_i);
				test_errs++;
			end
			if (gp_o[7:1] !== gp_model[7:1]) begin
				$display("** Error [%0s] gp_o[7:1] expected %h, got %h",
					test_name_i, gp_model[7:1], gp_o[7:1]);
				test_errs++;
			end
			if (gp_model[0] && gp_o[0] !== 1'b1) begin
				$display("** Error [%0s] gp_o[0] expected 1, got %b",
					test_name_i, gp_o[0]);
				test_errs++;
			end
			if (gp_o[0] && !gp_model[0]) begin
				act_seen = 1;
				if (idle_cnt >= 2) begin
					$display("[%0s] activity on gp_o[0] long after the last request",
						test_name_i);
					test_errs++;
				end
			end
		end
		s2_vld = s1_vld;
		s2_rd = s1_rd;
		s2_gp = s1_gp;
		s1_vld = (pi1_op_i != 2'd0) && (pi1_rdy_o === 1'b1);
		s1_rd = exp_rd_i;
		s1_gp = exp_gp_i;
		idle_cnt = s1_vld ? 0 : idle_cnt + 1;
		if (cond_chk_i && !cond_ok_i) begin
			$display("[%0s] %0s", test_name_i, cond_msg_i);
			test_errs++;
		end
		if (test_end_i) begin
			if (act_test_i && !act_seen) begin
				$display("[%0s] no activity pulse seen on gp_o[0]", test_name_i);
				test_errs++;
			end
			tests_run++;
			if (test_errs != 0)
				tests_failed++;
			$display("test %0s done, %0d errors", test_name_i, test_errs);
			err_cnt_o = err_cnt_o + test_errs;
			test_errs = 0;
			act_seen = 0;
		end
		if (all_done_i)
			$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt_o);
	end

endmodule

`default_nettype wire

// File: tests/soc_sysctl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module soc_sysctl_tb;

	// Test lengths in cycles, used for the watchdog
	localparam int T_INIT = 80;
	localparam int T_DEVTBL = 30;
	localparam int T_GPIO_OUT = 60;
	localparam int T_GPIO_IN = 60;
	localparam int T_INVALID = 50;
	localparam int T_SWRST = 380;
	localparam int T_ACT = 30;
	localparam int T_ALL = T_INIT + T_DEVTBL + T_GPIO_OUT + T_GPIO_IN + T_INVALID +
		T_SWRST + T_ACT + 200;

	logic clk_4x_w = 0;
	logic rst_p;
	soc_sysctl_pkg::pi1_op_e pi1_op;
	soc_sysctl_pkg::pi1_addr_t pi1_addr;
	soc_sysctl_pkg::arch_data_t pi1_wdata;
	soc_sysctl_pkg::byte_sel_t pi1_sel;
	soc_sysctl_pkg::gpio_t gp_i;
	soc_sysctl_pkg::arch_data_t pi1_rdata;
	soc_sysctl_pkg::gpio_t gp_o;
	logic pi1_rdy;
	logic sys_rst;

	logic [31:0] lfsr = 32'habbb_d8ed;
	logic [7:0] gp_model;
	logic [31:0] exp_rd;
	logic [8*16-1:0] test_name;
	logic test_end;
	logic all_done;
	logic act_test;
	logic cond_chk;
	logic cond_ok;
	logic [8*48-1:0] cond_msg;
	int err_cnt;

	always #5 clk_4x_w = ~clk_4x_w;

	soc_sysctl_top i_dut (
		.clk_4x_w(clk_4x_w),
		.rst_p(rst_p),
		.pi1_op_i(pi1_op),
		.pi1_addr_i(pi1_addr),
		.pi1_data_i(pi1_wdata),
		.pi1_sel_i(pi1_sel),
		.pi1_data_o(pi1_rdata),
		.pi1_rdy_o(pi1_rdy),
		.gp_i(gp_i),
		.gp_o(gp_o),
		.sys_rst_o(sys_rst)
	);

	soc_sysctl_mon i_mon (
		.clk_4x_w(clk_4x_w),
		.sys_rst_o(sys_rst),
		.pi1_rdy_o(pi1_rdy),
		.pi1_op_i(pi1_op),
		.pi1_data_o(pi1_rdata),
		.gp_o(gp_o),
		.exp_rd_i(exp_rd),
		.exp_gp_i(gp_model),
		.test_name_i(test_name),
		.test_end_i(test_end),
		.all_done_i(all_done),
		.act_test_i(act_test),
		.cond_chk_i(cond_chk),
		.cond_ok_i(cond_ok),
		.cond_msg_i(cond_msg),
		.err_cnt_o(err_cnt)
	);

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected read word from the register map
	function automatic logic [31:0] soc_ref_read(input logic [29:0] a, input logic [7:0] gpm,
		input logic [7:0] pins);
		logic [9:0] off;
		off = a[9:0];
		case (a[11:10])
			2'd0: begin
				if (off == 10'd0) return 32'(`SOC_ID_DEVTBL);
				if (off == 10'd1) return 32'(`SOC_ID_GPIO);
				if (off == 10'd2) return 32'(`SOC_ID_INVALID);
				return 32'd0;
			end
			2'd1: begin
				if (off == 10'(`SOC_GPIO_OUT_REG)) return {24'd0, gpm};
				if (off == 10'(`SOC_GPIO_IN_REG)) return {24'd0, pins};
				return 32'd0;
			end
			default: return 32'd0;
		endcase
	endfunction

	task automatic issue(input soc_sysctl_pkg::pi1_op_e op, input logic [29:0] a,
		input logic [31:0] d, input logic [3:0] s);
		exp_rd = (op == soc_sysctl_pkg::PI1_RD) ? soc_ref_read(a, gp_model, gp_i) : 32'd0;
		if (op == soc_sysctl_pkg::PI1_WR && a[11:10] == 2'd1 && a[9:0] == 10'd0 && s[0])
			gp_model = d[7:0];
		pi1_op = op;
		pi1_addr = a;
		pi1_wdata = d;
		pi1_sel = s;
		@(posedge clk_4x_w);
		#1;
		pi1_op = soc_sysctl_pkg::PI1_NOP;
	endtask

	task automatic idle(input int n);
		pi1_op = soc_sysctl_pkg::PI1_NOP;
		repeat (n) begin
			@(posedge clk_4x_w);
			#1;
		end
	endtask

	task automatic end_test();
		idle(3);
		test_end = 1;
		idle(1);
		test_end = 0;
	endtask

	task automatic check_cond(input logic ok, input logic [8*48-1:0] msg);
		cond_ok = ok;
		cond_msg = msg;
		cond_chk = 1;
		idle(1);
		cond_chk = 0;
	endtask

	task automatic sw_reset_pulse(input logic [1:0] v);
		logic rose;
		logic fell;
		logic [31:0] r;
		rose = 0;
		fell = 0;
		r = rand_bits(8);
		issue(soc_sysctl_pkg::PI1_WR, 30'h400, r | 32'h2, 4'h1);
		issue(soc_sysctl_pkg::PI1_WR, 30'(`SOC_DEVTBL_RSTREG), {30'd0, v}, 4'h1);
		for (int i = 0; i < 70 && !fell; i++) begin
			idle(1);
			if (sys_rst) rose = 1;
			if (rose && !sys_rst) fell = 1;
		end
		check_cond(rose && fell, "sys_rst_o did not pulse after a software reset");
		gp_model = 0;
		issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
	endtask

	initial begin
		#(T_ALL * 10);
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [29:0] a;
		logic rose;
		logic fell;
		rst_p = 1;
		pi1_op = soc_sysctl_pkg::PI1_NOP;
		pi1_addr = '0;
		pi1_wdata = '0;
		pi1_sel = '0;
		gp_i = '0;
		gp_model = '0;
		exp_rd = '0;
		test_name = "init";
		{test_end, all_done, act_test, cond_chk, cond_ok} = '0;
		cond_msg = '0;
		repeat (2) @(posedge clk_4x_w);
		#1;
		rst_p = 0;
		while (sys_rst !== 1'b0) idle(1);

		test_name = "devtbl";
		for (int k = 0; k < 6; k++)
			issue(soc_sysctl_pkg::PI1_RD, 30'(k), 0, 4'hf);
		issue(soc_sysctl_pkg::PI1_RD, 30'(`SOC_DEVTBL_RSTREG), 0, 4'hf);
		end_test();

		test_name = "gpio_out";
		for (int i = 0; i < 20; i++) begin
			d = rand_bits(32);
			r = rand_bits(4);
			issue(soc_sysctl_pkg::PI1_WR, 30'h400, d, r[3:0]);
			issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
		end
		// Byte enable 0 clear must leave the register alone
		issue(soc_sysctl_pkg::PI1_WR, 30'h400, ~{24'd0, gp_model}, 4'he);
		issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
		end_test();

		test_name = "gpio_in";
		for (int i = 0; i < 10; i++) begin
			r = rand_bits(8);
			gp_i = r[7:0];
			idle(3);
			issue(soc_sysctl_pkg::PI1_RD, 30'h401, 0, 4'hf);
			issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
		end
		end_test();

		test_name = "invalid";
		for (int i = 0; i < 10; i++) begin
			r = rand_bits(30);
			a = r[29:0];
			a[11] = 1'b1;
			d = rand_bits(32);
			issue(soc_sysctl_pkg::PI1_WR, a, d, 4'hf);
			issue(soc_sysctl_pkg::PI1_RD, a, 0, 4'hf);
		end
		// Same offsets as the reset register and the GPIO output, in unmapped slots
		issue(soc_sysctl_pkg::PI1_WR, 30'h8ff, 32'h3, 4'hf);
		issue(soc_sysctl_pkg::PI1_WR, 30'hc00, ~{24'd0, gp_model}, 4'hf);
		for (int k = 0; k < 3; k++)
			issue(soc_sysctl_pkg::PI1_RD, 30'(k), 0, 4'hf);
		issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
		check_cond(sys_rst === 1'b0, "a write to an unmapped slot reset the system");
		end_test();

		test_name = "sw_reset";
		sw_reset_pulse(2'd2);
		sw_reset_pulse(2'd3);
		// Power-off holds until the external reset
		r = rand_bits(8);
		issue(soc_sysctl_pkg::PI1_WR, 30'h400, r | 32'h2, 4'h1);
		issue(soc_sysctl_pkg::PI1_WR, 30'(`SOC_DEVTBL_RSTREG), 32'h1, 4'h1);
		rose = 0;
		fell = 0;
		for (int i = 0; i < 100; i++) begin
			idle(1);
			if (sys_rst) rose = 1;
			if (rose && !sys_rst) fell = 1;
		end
		check_cond(rose && !fell, "sys_rst_o did not stay high after power-off");
		rst_p = 1;
		idle(2);
		rst_p = 0;
		fell = 0;
		for (int i = 0; i < 80 && !fell; i++) begin
			idle(1);
			if (!sys_rst) fell = 1;
		end
		check_cond(fell, "sys_rst_o did not fall after rst_p");
		gp_model = '0;
		issue(soc_sysctl_pkg::PI1_RD, 30'h400, 0, 4'hf);
		end_test();

		// Output register is clear after the external reset
		test_name = "activity";
		act_test = 1;
		for (int i = 0; i < 8; i++)
			issue(soc_sysctl_pkg::PI1_RD, 30'(i % 3), 0, 4'hf);
		end_test();
		act_test = 0;

		all_done = 1;
		idle(1);
		all_done = 0;
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/pi1_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module pi1_decode (
	input wire logic clk_4x_w,
	input wire logic sys_rst_i,
	input soc_sysctl_pkg::pi1_op_e pi1_op_i,
	input soc_sysctl_pkg::pi1_addr_t pi1_addr_i,
	input soc_sysctl_pkg::arch_data_t pi1_data_i,
	input soc_sysctl_pkg::byte_sel_t pi1_sel_i,
	output logic pi1_rdy_o,
	output soc_sysctl_pkg::pi1_op_e dec_op_o,
	output soc_sysctl_pkg::slot_e dec_slot_o,
	output soc_sysctl_pkg::word_off_t dec_off_o,
	output soc_sysctl_pkg::arch_data_t dec_data_o,
	output soc_sysctl_pkg::byte_sel_t dec_sel_o
);

	logic accept_w;
	logic [`SOC_SLOT_W-1:0] slot_idx_w;
	soc_sysctl_pkg::slot_e slot_w;

	// No back-pressure, the bus is open whenever the system runs
	assign pi1_rdy_o = ~sys_rst_i;
	assign accept_w = (pi1_op_i != soc_sysctl_pkg::PI1_NOP) & pi1_rdy_o;

	assign slot_idx_w = pi1_addr_i[`SOC_SLOT_LSB +: `SOC_SLOT_W];

	// Unmapped indices fall to the default slave
	always_comb begin
		case (slot_idx_w)
			2'd0: slot_w = soc_sysctl_pkg::SLOT_DEVTBL;
			2'd1: slot_w = soc_sysctl_pkg::SLOT_GPIO;
			default: slot_w = soc_sysctl_pkg::SLOT_INVALID;
		endcase
	end

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			dec_op_o <= soc_sysctl_pkg::PI1_NOP;
		end else begin
			dec_op_o <= accept_w ? pi1_op_i : soc_sysctl_pkg::PI1_NOP;
		end
	end

	// Request payload, only meaningful alongside a valid op
	always_ff @(posedge clk_4x_w) begin
		if (accept_w) begin
			dec_slot_o <= slot_w;
			dec_off_o <= pi1_addr_i[`SOC_SLOT_LSB-1:0];
			dec_data_o <= pi1_data_i;
			dec_sel_o <= pi1_sel_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pi1_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module pi1_result (
	input wire logic clk_4x_w,
	input wire logic sys_rst_i,
	input soc_sysctl_pkg::pi1_op_e dec_op_i,
	input soc_sysctl_pkg::arch_data_t dt_rdata_i,
	input soc_sysctl_pkg::arch_data_t gpio_rdata_i,
	input soc_sysctl_pkg::gpio_t gpio_out_i,
	output soc_sysctl_pkg::arch_data_t pi1_data_o,
	output soc_sysctl_pkg::gpio_t gp_o
);

	logic activity_r;
	logic [`SOC_ACT_CNTR_W-1:0] act_cntr_r;

	// Idle slaves hold zero, so an OR is enough to merge them
	assign pi1_data_o = dt_rdata_i | gpio_rdata_i;

	// Activity pulse, the counter dims it by skipping cycles after each pulse
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			activity_r <= 1'b0;
			act_cntr_r <= '0;
		end else if (act_cntr_r != '0) begin
			activity_r <= 1'b0;
			act_cntr_r <= act_cntr_r - 1'b1;
		end else if (dec_op_i != soc_sysctl_pkg::PI1_NOP) begin
			activity_r <= 1'b1;
			act_cntr_r <= '1;
		end else begin
			activity_r <= 1'b0;
		end
	end

	assign gp_o = gpio_out_i | soc_sysctl_pkg::gpio_t'(activity_r);

endmodule

`default_nettype wire

// File: verilog/soc_devtbl.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module soc_devtbl (
	input wire logic clk_4x_w,
	input wire logic sys_rst_i,
	input soc_sysctl_pkg::pi1_op_e dec_op_i,
	input soc_sysctl_pkg::slot_e dec_slot_i,
	input soc_sysctl_pkg::word_off_t dec_off_i,
	input soc_sysctl_pkg::arch_data_t dec_data_i,
	input soc_sysctl_pkg::byte_sel_t dec_sel_i,
	output soc_sysctl_pkg::arch_data_t dt_rdata_o,
	output logic dt_rst0_o,
	output logic dt_rst1_o
);

	logic rd_hit_w;
	logic rst_wr_w;
	soc_sysctl_pkg::arch_data_t entry_w;

	// Table entry: interrupt-use flag in bit 31, device id in the low half
	function automatic soc_sysctl_pkg::arch_data_t dev_entry(
		input logic [15:0] id,
		input logic use_intr
	);
		return {use_intr, 15'd0, id};
	endfunction

	assign rd_hit_w = (dec_op_i == soc_sysctl_pkg::PI1_RD) &
		(dec_slot_i == soc_sysctl_pkg::SLOT_DEVTBL);

	assign rst_wr_w = (dec_op_i == soc_sysctl_pkg::PI1_WR) &
		(dec_slot_i == soc_sysctl_pkg::SLOT_DEVTBL) &
		(dec_off_i == soc_sysctl_pkg::word_off_t'(`SOC_DEVTBL_RSTREG)) &
		dec_sel_i[0];

	// Entry k describes slot k; nothing raises interrupts here
	always_comb begin
		case (dec_off_i)
			soc_sysctl_pkg::word_off_t'(soc_sysctl_pkg::SLOT_DEVTBL):
				entry_w = dev_entry(16'(`SOC_ID_DEVTBL), 1'b0);
			soc_sysctl_pkg::word_off_t'(soc_sysctl_pkg::SLOT_GPIO):
				entry_w = dev_entry(16'(`SOC_ID_GPIO), 1'b0);
			soc_sysctl_pkg::word_off_t'(soc_sysctl_pkg::SLOT_INVALID):
				entry_w = dev_entry(16'(`SOC_ID_INVALID), 1'b0);
			default:
				entry_w = '0;
		endcase
	end

	always_ff @(posedge clk_4x_w) begin
		dt_rdata_o <= rd_hit_w ? entry_w : '0;
	end

	// Reset request bits, seen by the sequencer one cycle later
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			dt_rst0_o <= 1'b0;
			dt_rst1_o <= 1'b0;
		end else if (rst_wr_w) begin
			dt_rst0_o <= dec_data_i[0];
			dt_rst1_o <= dec_data_i[1];
		end
	end

endmodule

`default_nettype wire

// File: verilog/soc_gpio.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module soc_gpio (
	input wire logic clk_4x_w,
	input wire logic sys_rst_i,
	input soc_sysctl_pkg::pi1_op_e dec_op_i,
	input soc_sysctl_pkg::slot_e dec_slot_i,
	input soc_sysctl_pkg::word_off_t dec_off_i,
	input soc_sysctl_pkg::arch_data_t dec_data_i,
	input soc_sysctl_pkg::byte_sel_t dec_sel_i,
	input soc_sysctl_pkg::gpio_t gp_i,
	output soc_sysctl_pkg::arch_data_t gpio_rdata_o,
	output soc_sysctl_pkg::gpio_t gpio_out_o
);

	soc_sysctl_pkg::gpio_t gp_meta_r;
	soc_sysctl_pkg::gpio_t gp_sync_r;
	logic sel_w;
	logic out_wr_w;
	logic rd_w;
	soc_sysctl_pkg::arch_data_t rword_w;

	assign sel_w = (dec_slot_i == soc_sysctl_pkg::SLOT_GPIO);
	assign rd_w = sel_w & (dec_op_i == soc_sysctl_pkg::PI1_RD);
	assign out_wr_w = sel_w & (dec_op_i == soc_sysctl_pkg::PI1_WR) &
		(dec_off_i == soc_sysctl_pkg::word_off_t'(`SOC_GPIO_OUT_REG)) & dec_sel_i[0];

	// Two flop synchronizer on the pins
	always_ff @(posedge clk_4x_w) begin
		gp_meta_r <= gp_i;
		gp_sync_r <= gp_meta_r;
	end

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
		end else if (out_wr_w) begin
			gpio_out_o <= dec_data_i[`SOC_GPIO_CNT-1:0];
		end
	end

	always_comb begin
		case (dec_off_i)
			soc_sysctl_pkg::word_off_t'(`SOC_GPIO_OUT_REG):
				rword_w = soc_sysctl_pkg::arch_data_t'(gpio_out_o);
			soc_sysctl_pkg::word_off_t'(`SOC_GPIO_IN_REG):
				rword_w = soc_sysctl_pkg::arch_data_t'(gp_sync_r);
			default:
				rword_w = '0;
		endcase
	end

	// Zero unless this slot is being read
	always_ff @(posedge clk_4x_w) begin
		gpio_rdata_o <= rd_w ? rword_w : '0;
	end

endmodule

`default_nettype wire

// File: verilog/soc_rst_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_sysctl_cfg.svh"

module soc_rst_seq (
	input wire logic clk_4x_w,
	input wire logic rst_p,
	input wire logic dt_rst0_i,
	input wire logic dt_rst1_i,
	output logic sys_rst_o
);

	logic [`SOC_RST_CNTR_W-1:0] rst_cntr_r;
	logic pwroff_r;
	logic cold_rst_w;
	logic warm_rst_w;
	logic pwroff_w;

	// Software request decoding from the device table reset bits
	assign cold_rst_w = dt_rst1_i & dt_rst0_i;
	assign warm_rst_w = dt_rst1_i & ~dt_rst0_i;
	assign pwroff_w = ~dt_rst1_i & dt_rst0_i;

	// Without a global set/reset primitive a cold reset just restarts the count
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			rst_cntr_r <= '1;
		end else if (cold_rst_w | warm_rst_w) begin
			rst_cntr_r <= '1;
		end else if (rst_cntr_r != '0) begin
			rst_cntr_r <= rst_cntr_r - 1'b1;
		end
	end

	// Power-off holds the system until the next external reset
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			pwroff_r <= 1'b0;
		end else if (pwroff_w) begin
			pwroff_r <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr_r != '0) | pwroff_r;

endmodule

`default_nettype wire

// File: verilog/soc_sysctl_cfg.svh
`ifndef SOC_SYSCTL_CFG_SVH
`define SOC_SYSCTL_CFG_SVH

// Bus geometry
`define SOC_ARCH_W 32
`define SOC_ADDR_W 30

// Slot index sits above the word offset, each slot is 1024 words
`define SOC_SLOT_LSB 10
`define SOC_SLOT_W 2

`define SOC_GPIO_CNT 8

// Counter sizes
`define SOC_RST_CNTR_W 6
`define SOC_ACT_CNTR_W 1

// Device table layout and ids
`define SOC_DEVTBL_RSTREG 255
`define SOC_ID_DEVTBL 7
`define SOC_ID_GPIO 6
`define SOC_ID_INVALID 0

// GPIO register map
`define SOC_GPIO_OUT_REG 0
`define SOC_GPIO_IN_REG 1

`endif

// File: verilog/soc_sysctl_pkg.sv
`default_nettype none

`include "soc_sysctl_cfg.svh"

package soc_sysctl_pkg;

	typedef logic [`SOC_ARCH_W-1:0] arch_data_t;
	typedef logic [`SOC_ADDR_W-1:0] pi1_addr_t;
	typedef logic [(`SOC_ARCH_W/8)-1:0] byte_sel_t;
	typedef logic [`SOC_SLOT_LSB-1:0] word_off_t;
	typedef logic [`SOC_GPIO_CNT-1:0] gpio_t;

	// PI1 operation code as driven by the master
	typedef enum logic [1:0] {
		PI1_NOP = 2'd0,
		PI1_WR = 2'd1,
		PI1_RD = 2'd2
	} pi1_op_e;

	// Slot value doubles as the device table entry index
	typedef enum logic [`SOC_SLOT_W-1:0] {
		SLOT_DEVTBL = 2'd0,
		SLOT_GPIO = 2'd1,
		SLOT_INVALID = 2'd2
	} slot_e;

endpackage

`default_nettype wire

// File: verilog/soc_sysctl_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_sysctl_top (
	input wire logic clk_4x_w,
	input wire logic rst_p,
	input soc_sysctl_pkg::pi1_op_e pi1_op_i,
	input soc_sysctl_pkg::pi1_addr_t pi1_addr_i,
	input soc_sysctl_pkg::arch_data_t pi1_data_i,
	input soc_sysctl_pkg::byte_sel_t pi1_sel_i,
	output soc_sysctl_pkg::arch_data_t pi1_data_o,
	output logic pi1_rdy_o,
	input soc_sysctl_pkg::gpio_t gp_i,
	output soc_sysctl_pkg::gpio_t gp_o,
	output logic sys_rst_o
);

	// Decode stage outputs
	soc_sysctl_pkg::pi1_op_e dec_op_w;
	soc_sysctl_pkg::slot_e dec_slot_w;
	soc_sysctl_pkg::word_off_t dec_off_w;
	soc_sysctl_pkg::arch_data_t dec_data_w;
	soc_sysctl_pkg::byte_sel_t dec_sel_w;

	// Slave read words and side outputs
	soc_sysctl_pkg::arch_data_t dt_rdata_w;
	soc_sysctl_pkg::arch_data_t gpio_rdata_w;
	soc_sysctl_pkg::gpio_t gpio_out_w;
	logic dt_rst0_w;
	logic dt_rst1_w;

	soc_rst_seq i_rst_seq (
		.clk_4x_w(clk_4x_w),
		.rst_p(rst_p),
		.dt_rst0_i(dt_rst0_w),
		.dt_rst1_i(dt_rst1_w),
		.sys_rst_o(sys_rst_o)
	);

	pi1_decode i_decode (
		.clk_4x_w(clk_4x_w),
		.sys_rst_i(sys_rst_o),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.pi1_rdy_o(pi1_rdy_o),
		.dec_op_o(dec_op_w),
		.dec_slot_o(dec_slot_w),
		.dec_off_o(dec_off_w),
		.dec_data_o(dec_data_w),
		.dec_sel_o(dec_sel_w)
	);

	soc_devtbl i_devtbl (
		.clk_4x_w(clk_4x_w),
		.sys_rst_i(sys_rst_o),
		.dec_op_i(dec_op_w),
		.dec_slot_i(dec_slot_w),
		.dec_off_i(dec_off_w),
		.dec_data_i(dec_data_w),
		.dec_sel_i(dec_sel_w),
		.dt_rdata_o(dt_rdata_w),
		.dt_rst0_o(dt_rst0_w),
		.dt_rst1_o(dt_rst1_w)
	);

	soc_gpio i_gpio (
		.clk_4x_w(clk_4x_w),
		.sys_rst_i(sys_rst_o),
		.dec_op_i(dec_op_w),
		.dec_slot_i(dec_slot_w),
		.dec_off_i(dec_off_w),
		.dec_data_i(dec_data_w),
		.dec_sel_i(dec_sel_w),
		.gp_i(gp_i),
		.gpio_rdata_o(gpio_rdata_w),
		.gpio_out_o(gpio_out_w)
	);

	pi1_result i_result (
		.clk_4x_w(clk_4x_w),
		.sys_rst_i(sys_rst_o),
		.dec_op_i(dec_op_w),
		.dt_rdata_i(dt_rdata_w),
		.gpio_rdata_i(gpio_rdata_w),
		.gpio_out_i(gpio_out_w),
		.pi1_data_o(pi1_data_o),
		.gp_o(gp_o)
	);

endmodule

`default_nettype wire
